//--- Makefile
TOP := nn_accel_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f nn_accel.f

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f nn_accel.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx 'ALL TESTS PASSED'

clean:
	rm -rf obj_dir

//--- design/argmax_unit.sv
`timescale 1ns/1ps

module argmax_unit #(
    parameter int MAX_NEURONS = 64
) (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                value_valid_i,
    input  nn_accel_pkg::word_t value_i,
    input  logic                last_i,
    output logic                done_o,
    output nn_accel_pkg::word_t class_o
);
    import nn_accel_pkg::*;

    localparam int IDX_W = $clog2(MAX_NEURONS);

    logic [IDX_W-1:0] idx_q;        // index of incoming value
    logic [IDX_W-1:0] best_idx_q;
    word_t            best_q;
    logic             take;

    // first value always taken, later only on strictly greater
    assign take = (idx_q == '0) || ($signed(value_i) > $signed(best_q));

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            idx_q   <= '0;
            done_o  <= 1'b0;
            class_o <= '0;
        end else begin
            done_o <= 1'b0;
            if (value_valid_i) begin
                if (last_i) begin
                    done_o  <= 1'b1;
                    class_o <= word_t'(take ? idx_q : best_idx_q);
                    idx_q   <= '0;               // ready for next run
                end else begin
                    idx_q <= idx_q + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (value_valid_i && take) begin
            best_q     <= value_i;
            best_idx_q <= idx_q;
        end
    end

    a_done_pulse : assert property (
        @(posedge clk_i) disable iff (rst_i) done_o |=> !done_o
    );

endmodule

//--- design/mac_pipeline.sv
`timescale 1ns/1ps

module mac_pipeline (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  nn_accel_pkg::mac_op_t op_i,
    output logic                  sum_valid_o,
    output nn_accel_pkg::word_t   sum_o
);
    import nn_accel_pkg::*;

    logic signed [2*XLEN-1:0] prod_full;

    logic  s1_valid_q;
    logic  s1_first_q;
    logic  s1_last_q;
    word_t s1_prod_q;

    word_t acc_q;
    word_t acc_next;

    // ============================================================
    // stage 1  multiply and rescale
    // ============================================================
    assign prod_full = $signed(op_i.neuron) * $signed(op_i.weight);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            s1_valid_q <= 1'b0;
        end else begin
            s1_valid_q <= op_i.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        s1_first_q <= op_i.first;
        s1_last_q  <= op_i.last;
        s1_prod_q  <= word_t'(prod_full >>> FRAC_BITS);   // arithmetic, keep low word
    end

    // ============================================================
    // stage 2  accumulate, relu on last
    // ============================================================
    assign acc_next = s1_first_q ? s1_prod_q : acc_q + s1_prod_q;   // wraps

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            sum_valid_o <= 1'b0;
        end else begin
            sum_valid_o <= s1_valid_q && s1_last_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (s1_valid_q) begin
            acc_q <= acc_next;
        end
        if (s1_valid_q && s1_last_q) begin
            sum_o <= acc_next[XLEN-1] ? '0 : acc_next;   // clamp negatives
        end
    end

endmodule

//--- design/nn_accel_pkg.sv
package nn_accel_pkg;

    // ============================================================
    // widths
    // ============================================================
    localparam int XLEN           = 32;
    localparam int WORDS_PER_LINE = 4;
    localparam int LINE_W         = XLEN * WORDS_PER_LINE;   // 128 bit line
    localparam int FRAC_BITS      = 16;                      // q16.16
    localparam int MAX_LAYERS     = 4;

    typedef logic [XLEN-1:0] word_t;

    localparam word_t FX_ONE = word_t'(1) << FRAC_BITS;      // bias input

    // ============================================================
    // descriptor and line views
    // ============================================================
    // header line, word 0 sits in the low bits
    typedef struct packed {
        word_t spare;
        word_t total_layers;
        word_t weights_base;
        word_t neurons_base;
    } desc_hdr_t;

    typedef union packed {
        word_t [WORDS_PER_LINE-1:0] words;   // plain word view
        desc_hdr_t                  hdr;     // line 0 of a descriptor
    } line_u;

    // ============================================================
    // ports
    // ============================================================
    typedef struct packed {
        logic  strobe;   // one cycle
        logic  rw;       // 1 = write
        word_t addr;     // byte address of a word
        word_t wdata;
    } mem_req_t;

    typedef struct packed {
        logic  ready;
        line_u line;     // aligned line holding addr
    } mem_rsp_t;

    // one neuron/weight pair into the mac
    typedef struct packed {
        logic  valid;
        logic  first;    // restart accumulator
        logic  last;     // bias term, close the sum
        word_t neuron;
        word_t weight;
    } mac_op_t;

endpackage

//--- design/nn_accel_top.sv
`timescale 1ns/1ps

module nn_accel_top #(
    parameter int MAX_NEURONS = 64
) (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   cmd_strobe_i,
    input  nn_accel_pkg::word_t    cmd_addr_i,
    output nn_accel_pkg::mem_req_t mem_req_o,
    input  nn_accel_pkg::mem_rsp_t mem_rsp_i,
    output logic                   done_o,
    output nn_accel_pkg::word_t    class_o
);
    import nn_accel_pkg::*;

    // stream side
    logic       wload;
    logic       nload;
    line_u      load_line;
    logic [1:0] load_pos;
    logic       wpop;
    logic       npop;
    word_t      wword;
    word_t      nword;
    logic       whas;
    logic       nhas;

    // mac and argmax side
    mac_op_t    mac_op;
    logic       sum_valid;
    word_t      sum;
    logic       amax_valid;
    word_t      amax_value;
    logic       amax_last;

    // ============================================================
    // control
    // ============================================================
    nn_sequencer #(
        .MAX_NEURONS (MAX_NEURONS)
    ) u_sequencer (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .cmd_strobe_i (cmd_strobe_i),
        .cmd_addr_i   (cmd_addr_i),
        .mem_req_o    (mem_req_o),
        .mem_rsp_i    (mem_rsp_i),
        .wload_o      (wload),
        .nload_o      (nload),
        .load_line_o  (load_line),
        .load_pos_o   (load_pos),
        .wpop_o       (wpop),
        .npop_o       (npop),
        .wword_i      (wword),
        .nword_i      (nword),
        .whas_i       (whas),
        .nhas_i       (nhas),
        .mac_op_o     (mac_op),
        .sum_valid_i  (sum_valid),
        .sum_i        (sum),
        .amax_valid_o (amax_valid),
        .amax_value_o (amax_value),
        .amax_last_o  (amax_last)
    );

    // ============================================================
    // decode  weight and neuron streams share the line bus
    // ============================================================
    word_stream u_weights (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .load_i     (wload),
        .line_i     (load_line),
        .pos_i      (load_pos),
        .pop_i      (wpop),
        .word_o     (wword),
        .has_word_o (whas)
    );

    word_stream u_neurons (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .load_i     (nload),
        .line_i     (load_line),
        .pos_i      (load_pos),
        .pop_i      (npop),
        .word_o     (nword),
        .has_word_o (nhas)
    );

    // ============================================================
    // execute and result
    // ============================================================
    mac_pipeline u_mac (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .op_i        (mac_op),
        .sum_valid_o (sum_valid),
        .sum_o       (sum)
    );

    argmax_unit #(
        .MAX_NEURONS (MAX_NEURONS)
    ) u_argmax (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .value_valid_i (amax_valid),
        .value_i       (amax_value),
        .last_i        (amax_last),
        .done_o        (done_o),
        .class_o       (class_o)
    );

endmodule

//--- design/nn_sequencer.sv
`timescale 1ns/1ps

module nn_sequencer #(
    parameter int MAX_NEURONS = 64
) (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   cmd_strobe_i,
    input  nn_accel_pkg::word_t    cmd_addr_i,
    output nn_accel_pkg::mem_req_t mem_req_o,
    input  nn_accel_pkg::mem_rsp_t mem_rsp_i,
    output logic                   wload_o,
    output logic                   nload_o,
    output nn_accel_pkg::line_u    load_line_o,
    output logic [1:0]             load_pos_o,
    output logic                   wpop_o,
    output logic                   npop_o,
    input  nn_accel_pkg::word_t    wword_i,
    input  nn_accel_pkg::word_t    nword_i,
    input  logic                   whas_i,
    input  logic                   nhas_i,
    output nn_accel_pkg::mac_op_t  mac_op_o,
    input  logic                   sum_valid_i,
    input  nn_accel_pkg::word_t    sum_i,
    output logic                   amax_valid_o,
    output nn_accel_pkg::word_t    amax_value_o,
    output logic                   amax_last_o
);
    import nn_accel_pkg::*;

    localparam int CNT_W = $clog2(MAX_NEURONS) + 1;   // holds a full layer size
    localparam int LAY_W = $clog2(MAX_LAYERS);

    typedef enum logic [2:0] {
        S_IDLE, S_HDR, S_SIZE, S_RUN, S_WFILL, S_NFILL, S_SUM, S_WB
    } state_e;

    state_e           state_q;
    logic             pend_q;                  // request in flight
    logic [CNT_W-1:0] sizes_q [MAX_LAYERS];
    logic [LAY_W:0]   total_layers_q;
    logic [LAY_W-1:0] layer_q;                 // layer being computed
    logic [CNT_W-1:0] neuron_q;                // neuron within layer
    logic [CNT_W-1:0] in_cnt_q;                // pairs issued so far
    logic             n_stale_q;               // neuron stream holds old words
    logic             w_stale_q;               // weight stream left over from last run
    word_t            nbase_q;
    word_t            waddr_q;                 // next weight word
    word_t            naddr_q;                 // next input word
    word_t            prev_base_q;
    word_t            cur_base_q;

    logic [CNT_W-1:0] n_prev;
    logic             bias_step;
    logic             n_need;
    logic             w_ok;
    logic             issue;
    logic             last_neuron;
    logic             last_layer;

    function automatic mem_req_t rd_req(input word_t addr);
        rd_req = '{strobe: 1'b1, rw: 1'b0, addr: addr, wdata: '0};
    endfunction

    // ============================================================
    // pair issue
    // ============================================================
    assign n_prev      = sizes_q[layer_q - 1'b1];
    assign bias_step   = (in_cnt_q == n_prev);          // inputs done, bias next
    assign n_need      = !bias_step && (n_stale_q || !nhas_i);
    assign w_ok        = whas_i && !w_stale_q;          // weight word of this run
    assign issue       = (state_q == S_RUN) && w_ok && !n_need;
    assign last_neuron = (neuron_q == sizes_q[layer_q] - 1'b1);
    assign last_layer  = ({1'b0, layer_q} == total_layers_q - 1'b1);

    assign wpop_o = issue;
    assign npop_o = issue && !bias_step;

    always_comb begin
        mac_op_o.valid  = issue;
        mac_op_o.first  = (in_cnt_q == '0);
        mac_op_o.last   = bias_step;
        mac_op_o.neuron = bias_step ? FX_ONE : nword_i;
        mac_op_o.weight = wword_i;
    end

    // refills land straight in the streams
    assign wload_o     = (state_q == S_WFILL) && mem_rsp_i.ready;
    assign nload_o     = (state_q == S_NFILL) && mem_rsp_i.ready;
    assign load_line_o = mem_rsp_i.line;
    assign load_pos_o  = (state_q == S_WFILL) ? waddr_q[3:2] : naddr_q[3:2];

    // argmax sees a value once its write is acked
    assign amax_valid_o = (state_q == S_WB) && mem_rsp_i.ready && last_layer;
    assign amax_value_o = mem_req_o.wdata;
    assign amax_last_o  = last_neuron;

    // ============================================================
    // fsm
    // ============================================================
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q          <= S_IDLE;
            mem_req_o.strobe <= 1'b0;
            pend_q           <= 1'b0;
        end else begin
            mem_req_o.strobe <= 1'b0;                      // pulse only
            if (mem_req_o.strobe) begin
                pend_q <= 1'b1;
            end else if (mem_rsp_i.ready) begin
                pend_q <= 1'b0;
            end

            case (state_q)
                S_IDLE: if (cmd_strobe_i) begin            // busy otherwise
                    mem_req_o <= rd_req(cmd_addr_i);
                    state_q   <= S_HDR;
                end
                S_HDR: if (mem_rsp_i.ready) begin
                    nbase_q        <= mem_rsp_i.line.hdr.neurons_base;
                    waddr_q        <= mem_rsp_i.line.hdr.weights_base;
                    total_layers_q <= mem_rsp_i.line.hdr.total_layers[LAY_W:0];
                    mem_req_o      <= rd_req(mem_req_o.addr + word_t'(16));   // sizes line
                    state_q        <= S_SIZE;
                end
                S_SIZE: if (mem_rsp_i.ready) begin
                    for (int k = 0; k < MAX_LAYERS; k++) begin
                        sizes_q[k] <= mem_rsp_i.line.words[k][CNT_W-1:0];
                    end
                    layer_q     <= LAY_W'(1);
                    neuron_q    <= '0;
                    in_cnt_q    <= '0;
                    n_stale_q   <= 1'b1;
                    w_stale_q   <= 1'b1;                   // new weights base
                    prev_base_q <= nbase_q;
                    naddr_q     <= nbase_q;
                    cur_base_q  <= nbase_q + (word_t'(mem_rsp_i.line.words[0][CNT_W-1:0]) << 2);
                    state_q     <= S_RUN;
                end
                S_RUN: begin
                    if (issue) begin
                        in_cnt_q <= in_cnt_q + 1'b1;
                        waddr_q  <= waddr_q + word_t'(4);
                        if (!bias_step) begin
                            naddr_q <= naddr_q + word_t'(4);
                        end else begin
                            state_q <= S_SUM;              // wait out the mac
                        end
                    end else if (!w_ok) begin
                        mem_req_o <= rd_req(waddr_q);
                        state_q   <= S_WFILL;
                    end else begin
                        mem_req_o <= rd_req(naddr_q);
                        state_q   <= S_NFILL;
                    end
                end
                S_WFILL: if (mem_rsp_i.ready) begin
                    w_stale_q <= 1'b0;
                    state_q   <= S_RUN;
                end
                S_NFILL: if (mem_rsp_i.ready) begin
                    n_stale_q <= 1'b0;
                    state_q   <= S_RUN;
                end
                S_SUM: if (sum_valid_i) begin
                    mem_req_o <= '{strobe: 1'b1, rw: 1'b1,
                                   addr: cur_base_q + (word_t'(neuron_q) << 2),
                                   wdata: sum_i};
                    state_q   <= S_WB;
                end
                S_WB: if (mem_rsp_i.ready) begin
                    in_cnt_q  <= '0;
                    n_stale_q <= 1'b1;                     // inputs restart
                    if (!last_neuron) begin
                        neuron_q <= neuron_q + 1'b1;
                        naddr_q  <= prev_base_q;
                        state_q  <= S_RUN;
                    end else if (!last_layer) begin
                        layer_q     <= layer_q + 1'b1;
                        neuron_q    <= '0;
                        prev_base_q <= cur_base_q;
                        naddr_q     <= cur_base_q;
                        cur_base_q  <= cur_base_q + (word_t'(sizes_q[layer_q]) << 2);
                        state_q     <= S_RUN;
                    end else begin
                        state_q <= S_IDLE;                 // argmax raises done
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    a_one_outstanding : assert property (
        @(posedge clk_i) disable iff (rst_i) mem_req_o.strobe |-> !pend_q
    );

    a_layer_count : assert property (
        @(posedge clk_i) disable iff (rst_i)
        (state_q == S_HDR && mem_rsp_i.ready) |->
            (mem_rsp_i.line.hdr.total_layers >= 2 &&
             mem_rsp_i.line.hdr.total_layers <= MAX_LAYERS)
    );

endmodule

//--- design/word_stream.sv
`timescale 1ns/1ps

module word_stream (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                load_i,
    input  nn_accel_pkg::line_u line_i,
    input  logic [1:0]          pos_i,
    input  logic                pop_i,
    output nn_accel_pkg::word_t word_o,
    output logic                has_word_o
);
    import nn_accel_pkg::*;

    line_u      line_q;   // current line
    logic [2:0] ptr_q;    // bit 2 set = ran off the end

    // pointer, empty after reset
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ptr_q <= 3'd4;
        end else if (load_i) begin
            ptr_q <= {1'b0, pos_i};   // start mid line
        end else if (pop_i) begin
            ptr_q <= ptr_q + 3'd1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (load_i) begin
            line_q <= line_i;
        end
    end

    assign has_word_o = !ptr_q[2];             // low = needs a refill
    assign word_o     = line_q.words[ptr_q[1:0]];

    // sequencer only pops what it has seen
    a_no_pop_empty : assert property (
        @(posedge clk_i) disable iff (rst_i) pop_i |-> has_word_o
    );

endmodule

//--- nn_accel.f
design/nn_accel_pkg.sv
design/word_stream.sv
design/mac_pipeline.sv
design/argmax_unit.sv
design/nn_sequencer.sv
design/nn_accel_top.sv
sim/tb_clock_gen.sv
sim/nn_accel_tb.sv

//--- sim/nn_accel_tb.sv
`timescale 1ns/1ps

module nn_accel_tb;
    import nn_accel_pkg::*;

    localparam int MEM_WORDS = 2048;   // 8 KB, byte addr bits 12:2
    localparam int N_ROWS    = 4;

    // one network per row
    typedef struct packed {
        word_t           desc_addr;
        word_t           layers;
        logic [3:0][7:0] sizes;      // layer 3 down to layer 0
        word_t           nbase;
        word_t           wbase;
        word_t           wmin;       // signed q16.16
        word_t           wmax;
        logic            busy_cmd;   // extra strobe while running
    } row_t;

    logic     clk;
    logic     rst;
    logic     cmd_strobe;
    word_t    cmd_addr;
    mem_req_t mem_req;
    mem_rsp_t mem_rsp;
    logic     done;
    word_t    cls;

    row_t        rows        [N_ROWS];
    word_t       exp_class   [N_ROWS];
    int          exp_writes  [N_ROWS];
    int          exp_weights [N_ROWS];
    word_t       mem         [MEM_WORDS];   // what the DUT sees
    word_t       ref_mem     [MEM_WORDS];   // model neuron values
    bit          out_flag    [MEM_WORDS];   // word is a computed neuron
    int unsigned lcg_state = 32'd96648;
    int          err_cnt   = 0;
    int          check_cnt = 0;
    int          done_cnt  = 0;
    int          write_cnt = 0;
    word_t       last_class;
    int          wd_limit  = 0;
    bit          wd_armed  = 1'b0;

    tb_clock_gen u_clk (
        .clk_o (clk),
        .rst_o (rst)
    );

    nn_accel_top #(
        .MAX_NEURONS (64)
    ) u_dut (
        .clk_i        (clk),
        .rst_i        (rst),
        .cmd_strobe_i (cmd_strobe),
        .cmd_addr_i   (cmd_addr),
        .mem_req_o    (mem_req),
        .mem_rsp_i    (mem_rsp),
        .done_o       (done),
        .class_o      (cls)
    );

    // ============================================================
    // helpers
    // ============================================================
    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 8;   // low bits repeat too soon
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        longint span;
        span = longint'(hi) - longint'(lo) + 64'sd1;
        return lo + int'(longint'(lcg_next()) % span);
    endfunction

    function automatic int word_index(input word_t addr);
        return int'(addr[12:2]);
    endfunction

    task automatic compare_word(input string name, input word_t got, input word_t exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("MISMATCH time=%0t %s got=%h exp=%h", $time, name, got, exp);
        end
    endtask

    task automatic send_command(input word_t addr);
        @(posedge clk);
        #1;
        cmd_strobe = 1'b1;
        cmd_addr   = addr;
        @(posedge clk);
        #1;
        cmd_strobe = 1'b0;
    endtask

    task automatic load_table();
        // plain aligned 3 layer net, weights -0.5 .. 1.0
        rows[0] = '{desc_addr: 32'h0000, layers: 32'd3, sizes: {8'd0, 8'd3, 8'd6, 8'd4},
                    nbase: 32'h0100, wbase: 32'h0400,
                    wmin: 32'hFFFF_8000, wmax: 32'h0001_0000, busy_cmd: 1'b0};
        // odd bases, sizes off the line grid
        rows[1] = '{desc_addr: 32'h0800, layers: 32'd4, sizes: {8'd3, 8'd6, 8'd7, 8'd5},
                    nbase: 32'h0904, wbase: 32'h0A0C,
                    wmin: 32'hFFFF_0000, wmax: 32'h0001_0000, busy_cmd: 1'b0};
        // all weights negative, everything clamps
        rows[2] = '{desc_addr: 32'h1000, layers: 32'd3, sizes: {8'd0, 8'd5, 8'd4, 8'd3},
                    nbase: 32'h1108, wbase: 32'h1204,
                    wmin: 32'hFFFE_0000, wmax: 32'hFFFF_FF00, busy_cmd: 1'b0};
        // second strobe during the run
        rows[3] = '{desc_addr: 32'h1800, layers: 32'd2, sizes: {8'd0, 8'd0, 8'd5, 8'd6},
                    nbase: 32'h1840, wbase: 32'h1900,
                    wmin: 32'hFFFF_8000, wmax: 32'h0000_8000, busy_cmd: 1'b1};
    endtask

    // ============================================================
    // reference model, fills memory and expected values
    // ============================================================
    task automatic build_row(input int r);
        row_t   t;
        int     dw;
        int     nl;
        int     wi;
        int     best;
        int     sz [MAX_LAYERS];
        int     lw [MAX_LAYERS];   // first word index of each layer
        word_t  acc;
        word_t  x;
        word_t  w;
        longint prod;
        t  = rows[r];
        dw = word_index(t.desc_addr);
        nl = int'(t.layers);
        for (int k = 0; k < MAX_LAYERS; k++) begin
            sz[k] = (k < nl) ? int'(t.sizes[k]) : 0;
        end
        mem[dw]     = t.nbase;   // header line
        mem[dw + 1] = t.wbase;
        mem[dw + 2] = t.layers;
        mem[dw + 3] = '0;
        for (int k = 0; k < MAX_LAYERS; k++) begin
            mem[dw + 4 + k] = word_t'(sz[k]);   // sizes line
        end
        lw[0] = word_index(t.nbase);
        for (int k = 1; k < MAX_LAYERS; k++) begin
            lw[k] = lw[k - 1] + sz[k - 1];
        end
        for (int i = 0; i < sz[0]; i++) begin
            mem[lw[0] + i]     = word_t'(rand_range(0, 2 * int'(FX_ONE)));   // 0 .. 2.0
            ref_mem[lw[0] + i] = mem[lw[0] + i];
        end
        wi             = word_index(t.wbase);
        exp_writes[r]  = 0;
        exp_weights[r] = 0;
        for (int l = 1; l < nl; l++) begin
            for (int j = 0; j < sz[l]; j++) begin
                acc = '0;
                for (int i = 0; i <= sz[l - 1]; i++) begin
                    w       = word_t'(rand_range(int'(t.wmin), int'(t.wmax)));
                    mem[wi] = w;
                    wi++;
                    // last weight is the bias, paired with 1.0
                    x    = (i == sz[l - 1]) ? FX_ONE : ref_mem[lw[l - 1] + i];
                    prod = (longint'(int'(x)) * longint'(int'(w))) >>> FRAC_BITS;
                    acc  = acc + word_t'(prod);   // wraps at 32 bits
                end
                if (acc[XLEN-1]) begin
                    acc = '0;
                end
                ref_mem[lw[l] + j]  = acc;
                out_flag[lw[l] + j] = 1'b1;
                exp_writes[r]++;
            end
            exp_weights[r] += (sz[l - 1] + 1) * sz[l];
        end
        best = 0;   // lowest index wins a tie
        for (int j = 1; j < sz[nl - 1]; j++) begin
            if (int'(ref_mem[lw[nl - 1] + j]) > int'(ref_mem[lw[nl - 1] + best])) begin
                best = j;
            end
        end
        exp_class[r] = word_t'(best);
    endtask

    task automatic write_word(input mem_req_t req);
        int idx;
        idx = word_index(req.addr);
        if (!out_flag[idx]) begin
            err_cnt++;
            $display("write of %h to %h at %0t hits no output neuron", req.wdata, req.addr,
                     $time);
        end else begin
            compare_word("mem_req.wdata", req.wdata, ref_mem[idx]);
        end
        mem[idx] = req.wdata;
        write_cnt++;
    endtask

    // ============================================================
    // memory model, one request at a time, 1 to 4 cycle delay
    // ============================================================
    initial begin : memory_model
        mem_req_t req;
        int       delay;
        int       base;
        mem_rsp = '0;
        forever begin
            @(posedge clk);
            #1;
            mem_rsp.ready = 1'b0;   // ready is a one cycle pulse
            if (!rst && mem_req.strobe) begin
                req   = mem_req;
                delay = rand_range(1, 4);
                repeat (delay) @(posedge clk);
                #1;
                if (req.rw) begin
                    write_word(req);
                end else begin
                    base = word_index(req.addr) & ~3;   // aligned line
                    for (int k = 0; k < WORDS_PER_LINE; k++) begin
                        mem_rsp.line.words[k] = mem[base + k];
                    end
                end
                mem_rsp.ready = 1'b1;
            end
        end
    end

    // done pulses and class, sampled mid cycle
    always @(negedge clk) begin
        if (!rst && done) begin
            done_cnt++;
            last_class = cls;
        end
    end

    initial begin : watchdog
        wait (wd_armed);
        repeat (wd_limit) @(posedge clk);
        $display("timeout, no finish within %0d cycles", wd_limit);
        $display("checks %0d errors %0d", check_cnt, err_cnt + 1);
        $display("SOME TESTS FAILED");
        $finish;
    end

    // ============================================================
    // main sequence
    // ============================================================
    initial begin : main
        int start_done;
        int start_wr;
        int wd_sum;
        cmd_strobe = 1'b0;
        cmd_addr   = '0;
        load_table();
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i]      = word_t'(i) ^ 32'hA5A5_0000;   // fill tied to address
            ref_mem[i]  = mem[i];
            out_flag[i] = 1'b0;
        end
        wd_sum = 0;
        for (int r = 0; r < N_ROWS; r++) begin
            build_row(r);
            wd_sum += exp_weights[r] * 20;
        end
        wd_limit = wd_sum + 1000;   // reset and settle margin
        wd_armed = 1'b1;

        wait (!rst);
        repeat (4) begin   // quiet until the first command
            @(negedge clk);
            compare_word("done_o", word_t'(done), '0);
            compare_word("mem_req.strobe", word_t'(mem_req.strobe), '0);
        end

        for (int r = 0; r < N_ROWS; r++) begin
            start_done = done_cnt;
            start_wr   = write_cnt;
            send_command(rows[r].desc_addr);
            if (rows[r].busy_cmd) begin
                repeat (3) @(posedge clk);
                send_command(rows[0].desc_addr);   // engine busy, must be dropped
            end
            while (done_cnt == start_done) @(posedge clk);
            compare_word("class_o", last_class, exp_class[r]);
            repeat (12) begin   // engine idle, no queued run starts
                @(negedge clk);
                compare_word("mem_req.strobe", word_t'(mem_req.strobe), '0);
            end
            compare_word("done_count", word_t'(done_cnt - start_done), 32'd1);
            compare_word("write_count", word_t'(write_cnt - start_wr),
                         word_t'(exp_writes[r]));
        end

        $display("checks %0d errors %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- sim/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o,
    output logic rst_o
);

    // 40 ns period
    initial begin
        clk_o = 1'b0;
        forever #20 clk_o = ~clk_o;
    end

    // reset held for 5 rising edges, released just after the edge
    initial begin
        rst_o = 1'b1;
        repeat (5) @(posedge clk_o);
        #1 rst_o = 1'b0;
    end

endmodule
